/* Makefile */
TB_TOP = tb_flash_dump

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --top-module $(TB_TOP) -f flash_dump.f \
		--Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* char_link_if.sv */
`default_nettype none
`timescale 1ns/1ps

// character stream with credit return
interface char_link_if;
  import uart_pkg::*;

  logic  valid;
  char_t ch;
  logic  last;
  logic  credit;

  modport sender (
    output valid,
    output ch,
    output last,
    input  credit
  );

  modport receiver (
    input  valid,
    input  ch,
    input  last,
    output credit
  );

endinterface

`default_nettype wire

/* dump_pkg.sv */
`default_nettype none

package dump_pkg;

  // flash word address is page number plus low byte
  typedef logic [20:0] flash_addr_t;
  typedef logic [15:0] flash_word_t;
  typedef logic [7:0]  buf_addr_t;
  typedef logic [12:0] page_t;

  // dump layout
  localparam int dump_words    = 256;
  localparam int words_per_row = 16;

  // formatter walk through one dump
  typedef enum logic [3:0] {
    fmt_idle,
    fmt_wait_fill,
    fmt_row_digit,
    fmt_space,
    fmt_read_word,
    fmt_nibble,
    fmt_cr,
    fmt_lf,
    fmt_finish
  } fmt_state_t;

endpackage

`default_nettype wire

/* flash_dump.f */
dump_pkg.sv
uart_pkg.sv
char_link_if.sv
flash_reader.sv
hex_dump_formatter.sv
uart_tx.sv
flash_dump.sv
tb_flash_dump.sv

/* flash_dump.sv */
`default_nettype none
`timescale 1ns/1ps

module flash_dump #(
  parameter dump_pkg::page_t base_page = 13'h1fff,
  parameter int flash_wait_cycles = 6,
  parameter int clks_per_bit      = 6250,
  parameter int tx_queue_depth    = 4
) (
  input  logic                  clk_60M,
  input  logic                  rst,
  input  logic                  start,
  output dump_pkg::flash_addr_t flash_addr,
  input  dump_pkg::flash_word_t flash_data,
  output logic                  flash_we_n,
  output logic                  flash_oe_n,
  output logic                  flash_ce2,
  output logic                  trx,
  output logic                  done
);
  import dump_pkg::*;

  buf_addr_t   buf_raddr;
  flash_word_t buf_rdata;
  logic        buf_full;
  logic        running;
  logic        start_ok;

  char_link_if link ();

  // read only, never write the flash
  assign flash_we_n = 1'b1;

  // a new dump only once the previous one has finished
  assign start_ok = start && !running;

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      running <= 1'b0;
    end else if (start_ok) begin
      running <= 1'b1;
    end else if (done) begin
      running <= 1'b0;
    end
  end

  flash_reader #(
    .base_page        (base_page),
    .flash_wait_cycles(flash_wait_cycles)
  ) u_flash_reader (
    .clk_60M   (clk_60M),
    .rst       (rst),
    .start     (start_ok),
    .flash_addr(flash_addr),
    .flash_data(flash_data),
    .flash_oe_n(flash_oe_n),
    .flash_ce2 (flash_ce2),
    .buf_raddr (buf_raddr),
    .buf_rdata (buf_rdata),
    .buf_full  (buf_full)
  );

  hex_dump_formatter #(
    .tx_queue_depth(tx_queue_depth)
  ) u_hex_dump_formatter (
    .clk_60M  (clk_60M),
    .rst      (rst),
    .buf_full (buf_full),
    .buf_raddr(buf_raddr),
    .buf_rdata(buf_rdata),
    .link     (link.sender)
  );

  uart_tx #(
    .clks_per_bit  (clks_per_bit),
    .tx_queue_depth(tx_queue_depth)
  ) u_uart_tx (
    .clk_60M(clk_60M),
    .rst    (rst),
    .link   (link.receiver),
    .start  (start_ok),
    .trx    (trx),
    .done   (done)
  );

endmodule

`default_nettype wire

/* flash_reader.sv */
`default_nettype none
`timescale 1ns/1ps

module flash_reader #(
  parameter dump_pkg::page_t base_page = 13'h1fff,
  parameter int flash_wait_cycles = 6
) (
  input  logic                  clk_60M,
  input  logic                  rst,
  input  logic                  start,
  output dump_pkg::flash_addr_t flash_addr,
  input  dump_pkg::flash_word_t flash_data,
  output logic                  flash_oe_n,
  output logic                  flash_ce2,
  input  dump_pkg::buf_addr_t   buf_raddr,
  output dump_pkg::flash_word_t buf_rdata,
  output logic                  buf_full
);
  import dump_pkg::*;

  localparam int wait_w = (flash_wait_cycles > 0) ? $clog2(flash_wait_cycles + 1) : 1;

  flash_word_t       buf_ram [dump_words];
  buf_addr_t         addr_lo;
  logic [wait_w-1:0] wait_cnt;
  logic              busy;
  logic              capture;

  assign flash_addr = {base_page, addr_lo};
  assign capture    = busy && (wait_cnt == wait_w'(flash_wait_cycles));

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      busy       <= 1'b0;
      addr_lo    <= '0;
      wait_cnt   <= '0;
      buf_full   <= 1'b0;
      flash_oe_n <= 1'b1;
      flash_ce2  <= 1'b0;
    end else if (!busy) begin
      // a start during a fill is ignored
      if (start) begin
        busy       <= 1'b1;
        addr_lo    <= '0;
        wait_cnt   <= '0;
        buf_full   <= 1'b0;
        flash_oe_n <= 1'b0;
        flash_ce2  <= 1'b1;
      end
    end else if (capture) begin
      wait_cnt <= '0;
      if (addr_lo == buf_addr_t'(dump_words - 1)) begin
        busy       <= 1'b0;
        buf_full   <= 1'b1;
        flash_oe_n <= 1'b1;
        flash_ce2  <= 1'b0;
      end else begin
        addr_lo <= addr_lo + 1'b1;
      end
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // word lands once the access time has passed
  always_ff @(posedge clk_60M) begin
    if (capture) begin
      buf_ram[addr_lo] <= flash_data;
    end
  end

  always_ff @(posedge clk_60M) begin
    buf_rdata <= buf_ram[buf_raddr];
  end

endmodule

`default_nettype wire

/* hex_dump_formatter.sv */
`default_nettype none
`timescale 1ns/1ps

module hex_dump_formatter #(
  parameter int tx_queue_depth = 4
) (
  input  logic                  clk_60M,
  input  logic                  rst,
  input  logic                  buf_full,
  output dump_pkg::buf_addr_t   buf_raddr,
  input  dump_pkg::flash_word_t buf_rdata,
  char_link_if.sender           link
);
  import dump_pkg::*;
  import uart_pkg::*;

  localparam int cred_w = $clog2(tx_queue_depth + 1);

  fmt_state_t        state;
  buf_addr_t         word_idx;
  flash_word_t       word_q;
  logic [1:0]        nib_cnt;
  logic [cred_w-1:0] credits;
  logic              emit;
  logic              fire;
  logic              last_word;
  logic              last_col;
  char_t             cur_char;

  function automatic char_t hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      hex_char = 8'h30 + char_t'(nib);
    end else begin
      hex_char = 8'h57 + char_t'(nib);
    end
  endfunction

  assign buf_raddr = word_idx;
  assign last_word = (word_idx == buf_addr_t'(dump_words - 1));
  assign last_col  = (word_idx[3:0] == 4'(words_per_row - 1));

  // which character the current state offers
  always_comb begin
    emit     = 1'b0;
    cur_char = char_space;
    case (state)
      fmt_row_digit: begin
        emit     = 1'b1;
        cur_char = hex_char(word_idx[7:4]);
      end
      fmt_space: begin
        emit     = 1'b1;
        cur_char = char_space;
      end
      fmt_nibble: begin
        emit     = 1'b1;
        cur_char = hex_char(word_q[15:12]);
      end
      fmt_cr: begin
        emit     = 1'b1;
        cur_char = char_cr;
      end
      fmt_lf: begin
        emit     = 1'b1;
        cur_char = char_lf;
      end
      default: begin
        emit     = 1'b0;
        cur_char = char_space;
      end
    endcase
  end

  // no credit, no character; state and char just hold
  assign fire       = emit && (credits != '0);
  assign link.valid = fire;
  assign link.ch    = cur_char;
  assign link.last  = fire && (state == fmt_lf) && last_word;

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      credits <= cred_w'(tx_queue_depth);
    end else begin
      case ({fire, link.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      state    <= fmt_idle;
      word_idx <= '0;
      nib_cnt  <= '0;
    end else begin
      case (state)
        // buffer must drop first so a stale full is not taken as new
        fmt_idle: begin
          if (!buf_full) begin
            state <= fmt_wait_fill;
          end
        end
        fmt_wait_fill: begin
          if (buf_full) begin
            word_idx <= '0;
            state    <= fmt_row_digit;
          end
        end
        fmt_row_digit: begin
          if (fire) begin
            state <= fmt_space;
          end
        end
        fmt_space: begin
          if (fire) begin
            state <= fmt_read_word;
          end
        end
        fmt_read_word: begin
          nib_cnt <= '0;
          state   <= fmt_nibble;
        end
        fmt_nibble: begin
          if (fire) begin
            nib_cnt <= nib_cnt + 1'b1;
            if (nib_cnt == 2'd3) begin
              if (last_col) begin
                state <= fmt_cr;
              end else begin
                word_idx <= word_idx + 1'b1;
                state    <= fmt_space;
              end
            end
          end
        end
        fmt_cr: begin
          if (fire) begin
            state <= fmt_lf;
          end
        end
        fmt_lf: begin
          if (fire) begin
            if (last_word) begin
              state <= fmt_finish;
            end else begin
              word_idx <= word_idx + 1'b1;
              state    <= fmt_row_digit;
            end
          end
        end
        fmt_finish: begin
          state <= fmt_idle;
        end
        default: begin
          state <= fmt_idle;
        end
      endcase
    end
  end

  // word shifts left so the top nibble is always next
  always_ff @(posedge clk_60M) begin
    if (state == fmt_read_word) begin
      word_q <= buf_rdata;
    end else if (state == fmt_nibble && fire) begin
      word_q <= {word_q[11:0], 4'h0};
    end
  end

endmodule

`default_nettype wire

/* tb_flash_dump.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_flash_dump;
  import dump_pkg::*;
  import uart_pkg::*;

  localparam page_t page          = 13'h1fff;
  localparam int    wait_cycles   = 3;
  localparam int    bit_clks      = 8;
  localparam int    half_bit      = bit_clks / 2;
  localparam int    row_chars     = 1 + words_per_row * 5 + 2;
  localparam int    dump_total    = (dump_words / words_per_row) * row_chars;
  localparam int    fill_total    = dump_words * (wait_cycles + 1);
  localparam int    done_timeout  = 150000;
  localparam int    hold_cycles   = 200;
  localparam int    busy_start_at = 2 * fill_total;

  logic        clk_60M;
  logic        rst;
  logic        start;
  flash_addr_t flash_addr;
  flash_word_t flash_data;
  logic        flash_we_n;
  logic        flash_oe_n;
  logic        flash_ce2;
  logic        trx;
  logic        done;

  flash_word_t flash_mem [256];
  int          seed;
  int          value_errs;
  int          other_errs;
  int          dump_chars;
  int          fill_cycles;
  logic        timed_out;
  char_t       rx_q [$];
  logic        rx_busy;
  int          rx_cnt;
  char_t       rx_data;

  flash_dump #(
    .base_page        (page),
    .flash_wait_cycles(wait_cycles),
    .clks_per_bit     (bit_clks)
  ) u_flash_dump (
    .clk_60M   (clk_60M),
    .rst       (rst),
    .start     (start),
    .flash_addr(flash_addr),
    .flash_data(flash_data),
    .flash_we_n(flash_we_n),
    .flash_oe_n(flash_oe_n),
    .flash_ce2 (flash_ce2),
    .trx       (trx),
    .done      (done)
  );

  initial begin
    clk_60M = 1'b0;
    forever begin
      #5 clk_60M = ~clk_60M;
    end
  end

  // character at a given position of the dump text
  function automatic char_t expected_char(input int index, input flash_word_t mem [256]);
    string       digits;
    int          row;
    int          pos;
    int          col;
    int          k;
    flash_word_t w;
    logic [3:0]  nib;
    char_t       result;
    digits = "0123456789abcdef";
    row    = index / row_chars;
    pos    = index % row_chars;
    if (pos == 0) begin
      result = char_t'(digits[row]);
    end else if (pos == row_chars - 2) begin
      result = char_cr;
    end else if (pos == row_chars - 1) begin
      result = char_lf;
    end else begin
      col = (pos - 1) / 5;
      k   = (pos - 1) % 5;
      if (k == 0) begin
        result = char_space;
      end else begin
        w      = mem[row * words_per_row + col];
        nib    = 4'((w >> (16 - 4 * k)) & 16'h000f);
        result = char_t'(digits[int'(nib)]);
      end
    end
    return result;
  endfunction

  task automatic compare_char(input string name, input char_t got, input char_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic compare_word(input string name, input flash_word_t got,
                              input flash_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic fill_flash();
    for (int i = 0; i < 256; i++) begin
      flash_mem[i] = flash_word_t'($random(seed));
    end
  endtask

  task automatic pulse_start();
    @(posedge clk_60M);
    start <= 1'b1;
    @(posedge clk_60M);
    start <= 1'b0;
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // flash responds one cycle after the address
  always @(posedge clk_60M) begin
    flash_data <= flash_mem[flash_addr[7:0]];
  end

  always @(negedge clk_60M) begin
    if (!rst) begin
      compare_bit("flash_we_n", flash_we_n, 1'b1);
      if (flash_oe_n === 1'b0) begin
        fill_cycles++;
        compare_bit("flash_ce2", flash_ce2, 1'b1);
        compare_word("flash_addr page", flash_word_t'(flash_addr[20:8]),
                     flash_word_t'(page));
      end
    end
  end

  // serial receiver samples at bit centres
  always @(negedge clk_60M) begin
    int pt;
    int n;
    if (rst) begin
      rx_busy = 1'b0;
    end else if (!rx_busy) begin
      if (trx === 1'b0) begin
        rx_busy = 1'b1;
        rx_cnt  = 0;
      end
    end else begin
      rx_cnt = rx_cnt + 1;
      pt     = rx_cnt - half_bit;
      if (pt >= 0 && pt % bit_clks == 0) begin
        n = pt / bit_clks;
        if (n == 0) begin
          if (trx !== 1'b0) begin
            $display("bad frame: start bit is not low at its centre");
            other_errs++;
            rx_busy = 1'b0;
          end
        end else if (n <= 8) begin
          rx_data[n-1] = trx;
        end else begin
          if (trx !== 1'b1) begin
            $display("bad frame: stop bit is not high after char 0x%h", rx_data);
            other_errs++;
          end else begin
            rx_q.push_back(rx_data);
          end
          rx_busy = 1'b0;
        end
      end
    end
  end

  always @(posedge clk_60M) begin
    char_t got;
    while (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      if (dump_chars < dump_total) begin
        compare_char($sformatf("trx char %0d", dump_chars), got,
                     expected_char(dump_chars, flash_mem));
      end else begin
        $display("extra character 0x%h arrived after the end of the dump", got);
        other_errs++;
      end
      dump_chars++;
    end
  end

  task automatic run_dump(input int pass);
    int cycles;
    dump_chars  = 0;
    fill_cycles = 0;
    pulse_start();
    cycles = 0;
    @(negedge clk_60M);
    while (done !== 1'b1 && cycles < done_timeout) begin
      // a start while the dump is sent must be ignored
      if (cycles == busy_start_at) begin
        pulse_start();
      end
      @(negedge clk_60M);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("timeout: done did not rise during dump %0d", pass);
      other_errs++;
      timed_out = 1'b1;
    end else begin
      if (dump_chars != dump_total) begin
        $display("dump %0d: %0d characters before done, expected %0d",
                 pass, dump_chars, dump_total);
        other_errs++;
      end
      if (fill_cycles != fill_total) begin
        $display("dump %0d: flash read enabled for %0d cycles, expected %0d",
                 pass, fill_cycles, fill_total);
        other_errs++;
      end
      // done holds and the line stays quiet
      for (int i = 0; i < hold_cycles; i++) begin
        @(negedge clk_60M);
        compare_bit("done", done, 1'b1);
        compare_bit("trx", trx, 1'b1);
        compare_bit("flash_oe_n", flash_oe_n, 1'b1);
        compare_bit("flash_ce2", flash_ce2, 1'b0);
      end
      if (dump_chars != dump_total) begin
        $display("dump %0d: characters kept arriving after done", pass);
        other_errs++;
      end
    end
  endtask

  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    flash_data = '0;
    seed       = 27884;
    value_errs = 0;
    other_errs = 0;
    dump_chars = 0;
    timed_out  = 1'b0;
    fill_flash();
    repeat (4) @(posedge clk_60M);
    rst <= 1'b0;

    // idle line before any start
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_60M);
      compare_bit("trx", trx, 1'b1);
      compare_bit("done", done, 1'b0);
      compare_bit("flash_oe_n", flash_oe_n, 1'b1);
      compare_bit("flash_ce2", flash_ce2, 1'b0);
    end

    run_dump(1);
    if (!timed_out) begin
      fill_flash();
      run_dump(2);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  typedef logic [7:0] char_t;

  // line codes
  localparam char_t char_cr    = 8'h0d;
  localparam char_t char_lf    = 8'h0a;
  localparam char_t char_space = 8'h20;

  // 8N1 frame phases
  typedef enum logic [1:0] {
    tx_idle,
    tx_start_bit,
    tx_data_bits,
    tx_stop_bit
  } tx_state_t;

endpackage

`default_nettype wire

/* uart_tx.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit   = 6250,
  parameter int tx_queue_depth = 4
) (
  input  logic          clk_60M,
  input  logic          rst,
  char_link_if.receiver link,
  input  logic          start,
  output logic          trx,
  output logic          done
);
  import uart_pkg::*;

  localparam int ptr_w  = (tx_queue_depth > 1) ? $clog2(tx_queue_depth) : 1;
  localparam int cnt_w  = $clog2(tx_queue_depth + 1);
  localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  char_t             q_char [tx_queue_depth];
  logic              q_last [tx_queue_depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  q_count;
  logic              pop;
  tx_state_t         state;
  logic [baud_w-1:0] baud_cnt;
  logic              baud_end;
  logic [2:0]        bit_idx;
  char_t             shift;
  logic              last_q;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(tx_queue_depth - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  // credit goes back as the char moves into the shifter
  assign pop         = (state == tx_idle) && (q_count != '0);
  assign link.credit = pop;
  assign baud_end    = (baud_cnt == baud_w'(clks_per_bit - 1));

  always_ff @(posedge clk_60M) begin
    if (link.valid) begin
      q_char[wr_ptr] <= link.ch;
      q_last[wr_ptr] <= link.last;
    end
  end

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (link.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({link.valid, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  always_ff @(posedge clk_60M) begin
    if (pop) begin
      shift  <= q_char[rd_ptr];
      last_q <= q_last[rd_ptr];
    end else if (state == tx_data_bits && baud_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  always_ff @(posedge clk_60M) begin
    if (rst) begin
      state    <= tx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      trx      <= 1'b1;
      done     <= 1'b0;
    end else begin
      if (start) begin
        done <= 1'b0;
      end
      if (state != tx_idle) begin
        baud_cnt <= baud_end ? '0 : baud_cnt + 1'b1;
      end
      case (state)
        tx_idle: begin
          if (pop) begin
            baud_cnt <= '0;
            trx      <= 1'b0;
            state    <= tx_start_bit;
          end
        end
        tx_start_bit: begin
          if (baud_end) begin
            bit_idx <= '0;
            trx     <= shift[0];
            state   <= tx_data_bits;
          end
        end
        // lsb first
        tx_data_bits: begin
          if (baud_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              trx   <= 1'b1;
              state <= tx_stop_bit;
            end else begin
              trx <= shift[1];
            end
          end
        end
        tx_stop_bit: begin
          if (baud_end) begin
            state <= tx_idle;
            if (last_q) begin
              done <= 1'b1;
            end
          end
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire
